/* common/id_config.svh */
`ifndef ID_CONFIG_SVH
`define ID_CONFIG_SVH

// datapath widths
`define ID_WORD_W      32
`define ID_REG_ADDR_W  5

// credits granted by execute after reset
`define ID_CREDITS     4

// must hold the value ID_CREDITS
`define ID_CREDIT_W    3

`endif

/* common/id_pkg.sv */
`include "id_config.svh"

package id_pkg;

	typedef logic [`ID_WORD_W-1:0]     word_t;
	typedef logic [`ID_REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [31:0]               inst_t;
	typedef logic [7:0]                aluop_t;

	// value 3 (move group) left unused
	typedef enum logic [2:0] {
		sel_nop   = 3'd0,
		sel_logic = 3'd1,
		sel_shift = 3'd2,
		sel_arith = 3'd4
	} alusel_t;

	//////////////////////////////////////////////////
	// opcodes
	//////////////////////////////////////////////////
	localparam logic [5:0] op_special = 6'b000000;
	localparam logic [5:0] op_addi    = 6'b001000;
	localparam logic [5:0] op_addiu   = 6'b001001;
	localparam logic [5:0] op_slti    = 6'b001010;
	localparam logic [5:0] op_sltiu   = 6'b001011;
	localparam logic [5:0] op_andi    = 6'b001100;
	localparam logic [5:0] op_ori     = 6'b001101;
	localparam logic [5:0] op_xori    = 6'b001110;
	localparam logic [5:0] op_lui     = 6'b001111;

	//////////////////////////////////////////////////
	// SPECIAL funct codes
	//////////////////////////////////////////////////
	localparam logic [5:0] fn_sll  = 6'b000000;
	localparam logic [5:0] fn_srl  = 6'b000010;
	localparam logic [5:0] fn_sra  = 6'b000011;
	localparam logic [5:0] fn_sllv = 6'b000100;
	localparam logic [5:0] fn_srlv = 6'b000110;
	localparam logic [5:0] fn_srav = 6'b000111;
	localparam logic [5:0] fn_add  = 6'b100000;
	localparam logic [5:0] fn_addu = 6'b100001;
	localparam logic [5:0] fn_sub  = 6'b100010;
	localparam logic [5:0] fn_subu = 6'b100011;
	localparam logic [5:0] fn_and  = 6'b100100;
	localparam logic [5:0] fn_or   = 6'b100101;
	localparam logic [5:0] fn_xor  = 6'b100110;
	localparam logic [5:0] fn_nor  = 6'b100111;
	localparam logic [5:0] fn_slt  = 6'b101010;
	localparam logic [5:0] fn_sltu = 6'b101011;

endpackage

/* decode/id_decode.sv */
`timescale 1ns/1ps

module id_decode (
	input  logic              clk,
	input  logic              reset_n,
	input  id_pkg::inst_t     inst_i,
	input  logic              accept_i,
	output logic              issue_valid_o,
	output id_pkg::alusel_t   alusel_o,
	output id_pkg::aluop_t    aluop_o,
	output logic              wreg_o,
	output id_pkg::reg_addr_t waddr_o,
	output logic              reg1_read_o,
	output id_pkg::reg_addr_t reg1_addr_o,
	output logic              reg2_read_o,
	output id_pkg::reg_addr_t reg2_addr_o,
	output id_pkg::word_t     imm_o
);

	// instruction fields
	logic [5:0]        opcode;
	logic [5:0]        funct;
	logic [4:0]        shamt;
	logic [15:0]       imm16;
	id_pkg::reg_addr_t rs;
	id_pkg::reg_addr_t rt;
	id_pkg::reg_addr_t rd;

	// decoded, not yet registered
	id_pkg::alusel_t   dec_alusel;
	id_pkg::aluop_t    dec_aluop;
	logic              dec_wreg;
	id_pkg::reg_addr_t dec_waddr;
	logic              dec_reg1_read;
	logic              dec_reg2_read;
	id_pkg::word_t     dec_imm;

	assign opcode = inst_i[31:26];
	assign rs     = inst_i[25:21];
	assign rt     = inst_i[20:16];
	assign rd     = inst_i[15:11];
	assign shamt  = inst_i[10:6];
	assign funct  = inst_i[5:0];
	assign imm16  = inst_i[15:0];

	//////////////////////////////////////////////////
	// decode table
	//////////////////////////////////////////////////
	always_comb begin
		// anything not matched below issues as a bubble
		dec_alusel    = id_pkg::sel_nop;
		dec_aluop     = '0;
		dec_wreg      = 1'b0;
		dec_waddr     = '0;
		dec_reg1_read = 1'b0;
		dec_reg2_read = 1'b0;
		dec_imm       = '0;

		case (opcode)
			id_pkg::op_ori, id_pkg::op_andi, id_pkg::op_xori, id_pkg::op_lui: begin
				dec_alusel    = id_pkg::sel_logic;
				dec_aluop     = id_pkg::aluop_t'(opcode);
				dec_wreg      = 1'b1;
				dec_waddr     = rt;
				dec_reg1_read = 1'b1;
				dec_imm       = id_pkg::word_t'(imm16);
			end
			id_pkg::op_addi, id_pkg::op_addiu, id_pkg::op_slti, id_pkg::op_sltiu: begin
				dec_alusel    = id_pkg::sel_arith;
				dec_aluop     = id_pkg::aluop_t'(opcode);
				dec_wreg      = 1'b1;
				dec_waddr     = rt;
				dec_reg1_read = 1'b1;
				dec_imm       = id_pkg::word_t'($signed(imm16));
			end
			id_pkg::op_special: begin
				case (funct)
					id_pkg::fn_and, id_pkg::fn_or, id_pkg::fn_xor, id_pkg::fn_nor: begin
						dec_alusel    = id_pkg::sel_logic;
						dec_aluop     = id_pkg::aluop_t'(funct);
						dec_wreg      = 1'b1;
						dec_waddr     = rd;
						dec_reg1_read = 1'b1;
						dec_reg2_read = 1'b1;
					end
					// shift amount rides on operand 1
					id_pkg::fn_sll, id_pkg::fn_srl, id_pkg::fn_sra: begin
						dec_alusel    = id_pkg::sel_shift;
						dec_aluop     = id_pkg::aluop_t'(funct);
						dec_wreg      = 1'b1;
						dec_waddr     = rd;
						dec_reg2_read = 1'b1;
						dec_imm       = id_pkg::word_t'(shamt);
					end
					id_pkg::fn_sllv, id_pkg::fn_srlv, id_pkg::fn_srav: begin
						dec_alusel    = id_pkg::sel_shift;
						dec_aluop     = id_pkg::aluop_t'(funct);
						dec_wreg      = 1'b1;
						dec_waddr     = rd;
						dec_reg1_read = 1'b1;
						dec_reg2_read = 1'b1;
					end
					id_pkg::fn_add, id_pkg::fn_addu, id_pkg::fn_sub, id_pkg::fn_subu,
					id_pkg::fn_slt, id_pkg::fn_sltu: begin
						dec_alusel    = id_pkg::sel_arith;
						dec_aluop     = id_pkg::aluop_t'(funct);
						dec_wreg      = 1'b1;
						dec_waddr     = rd;
						dec_reg1_read = 1'b1;
						dec_reg2_read = 1'b1;
					end
					default: begin
					end
				endcase
			end
			default: begin
			end
		endcase
	end

	//////////////////////////////////////////////////
	// issue register
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			issue_valid_o <= 1'b0;
			alusel_o      <= id_pkg::sel_nop;
			aluop_o       <= '0;
			wreg_o        <= 1'b0;
			waddr_o       <= '0;
			reg1_read_o   <= 1'b0;
			reg1_addr_o   <= '0;
			reg2_read_o   <= 1'b0;
			reg2_addr_o   <= '0;
			imm_o         <= '0;
		end else if (accept_i) begin
			issue_valid_o <= 1'b1;
			alusel_o      <= dec_alusel;
			aluop_o       <= dec_aluop;
			wreg_o        <= dec_wreg;
			waddr_o       <= dec_waddr;
			reg1_read_o   <= dec_reg1_read;
			reg1_addr_o   <= rs;
			reg2_read_o   <= dec_reg2_read;
			reg2_addr_o   <= rt;
			imm_o         <= dec_imm;
		end else begin
			// fields hold, only the valid drops
			issue_valid_o <= 1'b0;
		end
	end

endmodule

/* rtl/id_top.sv */
`timescale 1ns/1ps

module id_top (
	input  logic              clk,
	input  logic              reset_n,
	// instruction in
	input  id_pkg::inst_t     inst_i,
	input  logic              inst_valid_i,
	output logic              inst_ready_o,
	// register file
	input  id_pkg::word_t     reg1_data_i,
	input  id_pkg::word_t     reg2_data_i,
	output logic              reg1_read_o,
	output id_pkg::reg_addr_t reg1_addr_o,
	output logic              reg2_read_o,
	output id_pkg::reg_addr_t reg2_addr_o,
	// execute and memory results
	input  logic              ex_we_i,
	input  id_pkg::reg_addr_t ex_waddr_i,
	input  id_pkg::word_t     ex_wdata_i,
	input  logic              mem_we_i,
	input  id_pkg::reg_addr_t mem_waddr_i,
	input  id_pkg::word_t     mem_wdata_i,
	// issue toward execute
	input  logic              credit_return_i,
	output logic              issue_valid_o,
	output id_pkg::alusel_t   alusel_o,
	output id_pkg::aluop_t    aluop_o,
	output logic              wreg_o,
	output id_pkg::reg_addr_t waddr_o,
	output id_pkg::word_t     reg1_data_o,
	output id_pkg::word_t     reg2_data_o
);

	logic          accept;
	id_pkg::word_t imm;

	issue_credit u_credit (
		.clk             (clk),
		.reset_n         (reset_n),
		.inst_valid_i    (inst_valid_i),
		.credit_return_i (credit_return_i),
		.inst_ready_o    (inst_ready_o),
		.accept_o        (accept)
	);

	id_decode u_decode (
		.clk           (clk),
		.reset_n       (reset_n),
		.inst_i        (inst_i),
		.accept_i      (accept),
		.issue_valid_o (issue_valid_o),
		.alusel_o      (alusel_o),
		.aluop_o       (aluop_o),
		.wreg_o        (wreg_o),
		.waddr_o       (waddr_o),
		.reg1_read_o   (reg1_read_o),
		.reg1_addr_o   (reg1_addr_o),
		.reg2_read_o   (reg2_read_o),
		.reg2_addr_o   (reg2_addr_o),
		.imm_o         (imm)
	);

	//////////////////////////////////////////////////
	// operand forwarding, one per source
	//////////////////////////////////////////////////
	operand_fwd u_fwd1 (
		.read_i      (reg1_read_o),
		.addr_i      (reg1_addr_o),
		.imm_i       (imm),
		.ex_we_i     (ex_we_i),
		.ex_waddr_i  (ex_waddr_i),
		.ex_wdata_i  (ex_wdata_i),
		.mem_we_i    (mem_we_i),
		.mem_waddr_i (mem_waddr_i),
		.mem_wdata_i (mem_wdata_i),
		.rf_data_i   (reg1_data_i),
		.data_o      (reg1_data_o)
	);

	operand_fwd u_fwd2 (
		.read_i      (reg2_read_o),
		.addr_i      (reg2_addr_o),
		.imm_i       (imm),
		.ex_we_i     (ex_we_i),
		.ex_waddr_i  (ex_waddr_i),
		.ex_wdata_i  (ex_wdata_i),
		.mem_we_i    (mem_we_i),
		.mem_waddr_i (mem_waddr_i),
		.mem_wdata_i (mem_wdata_i),
		.rf_data_i   (reg2_data_i),
		.data_o      (reg2_data_o)
	);

endmodule

/* rtl/issue_credit.sv */
`timescale 1ns/1ps
`include "id_config.svh"

module issue_credit (
	input  logic clk,
	input  logic reset_n,
	input  logic inst_valid_i,
	input  logic credit_return_i,
	output logic inst_ready_o,
	output logic accept_o
);

	localparam logic [`ID_CREDIT_W-1:0] credit_init = `ID_CREDITS;

	logic [`ID_CREDIT_W-1:0] credit_cnt;

	// no credit left means execute is full
	assign inst_ready_o = (credit_cnt != '0);
	assign accept_o     = inst_valid_i && inst_ready_o;

	//////////////////////////////////////////////////
	// credit counter
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			credit_cnt <= credit_init;
		end else begin
			case ({accept_o, credit_return_i})
				2'b10: begin
					credit_cnt <= credit_cnt - 1'b1;
				end
				// execute never returns more than it was given
				2'b01: begin
					credit_cnt <= credit_cnt + 1'b1;
				end
				default: begin
					credit_cnt <= credit_cnt;
				end
			endcase
		end
	end

endmodule

/* rtl/operand_fwd.sv */
`timescale 1ns/1ps

module operand_fwd (
	input  logic              read_i,
	input  id_pkg::reg_addr_t addr_i,
	input  id_pkg::word_t     imm_i,
	input  logic              ex_we_i,
	input  id_pkg::reg_addr_t ex_waddr_i,
	input  id_pkg::word_t     ex_wdata_i,
	input  logic              mem_we_i,
	input  id_pkg::reg_addr_t mem_waddr_i,
	input  id_pkg::word_t     mem_wdata_i,
	input  id_pkg::word_t     rf_data_i,
	output id_pkg::word_t     data_o
);

	logic ex_hit;
	logic mem_hit;

	// r0 gets no special treatment here
	assign ex_hit  = ex_we_i  && (ex_waddr_i  == addr_i);
	assign mem_hit = mem_we_i && (mem_waddr_i == addr_i);

	// youngest result first: execute, then memory, then register file
	always_comb begin
		if (!read_i)
			data_o = imm_i;
		else if (ex_hit)
			data_o = ex_wdata_i;
		else if (mem_hit)
			data_o = mem_wdata_i;
		else
			data_o = rf_data_i;
	end

endmodule

/* run.sh */
#!/bin/sh
# build and run the decode stage testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_id -f sim.f -o tb_id > build.log 2>&1 &&
	./obj_dir/tb_id > sim.log 2>&1 ||
	{ echo "build or run error, see build.log and sim.log"; exit 1; }
cat sim.log
if grep -q "Simulation failed" sim.log; then
	exit 1
fi
exit 0

/* sim.f */
+incdir+common
common/id_pkg.sv
decode/id_decode.sv
rtl/operand_fwd.sv
rtl/issue_credit.sv
rtl/id_top.sv
sim/id_sva.sv
sim/tb_id.sv

/* sim/id_sva.sv */
`timescale 1ns/1ps
`include "id_config.svh"

module id_sva (
	input logic                    clk,
	input logic                    reset_n,
	input logic                    inst_valid_i,
	input logic                    inst_ready_o,
	input logic                    issue_valid_o,
	input logic                    wreg_o,
	input id_pkg::alusel_t         alusel_o,
	input logic [`ID_CREDIT_W-1:0] credit_cnt_i
);

	// execute never hands back more than it took
	a_credit_bound: assert property (@(posedge clk) disable iff (!reset_n)
		credit_cnt_i <= `ID_CREDITS)
		else $error("credit count above the credits granted after reset");

	a_accept_issues: assert property (@(posedge clk) disable iff (!reset_n)
		(inst_valid_i && inst_ready_o) |=> issue_valid_o)
		else $error("accepted instruction not issued in the next cycle");

	// a bubble never writes
	a_nop_no_write: assert property (@(posedge clk) disable iff (!reset_n)
		!(wreg_o && alusel_o == id_pkg::sel_nop))
		else $error("wreg_o high with alusel_o at sel_nop");

endmodule

bind id_top id_sva u_sva (
	.clk           (clk),
	.reset_n       (reset_n),
	.inst_valid_i  (inst_valid_i),
	.inst_ready_o  (inst_ready_o),
	.issue_valid_o (issue_valid_o),
	.wreg_o        (wreg_o),
	.alusel_o      (alusel_o),
	.credit_cnt_i  (u_credit.credit_cnt)
);

/* sim/tb_id.sv */
`timescale 1ns/1ps
`include "id_config.svh"

module tb_id;

	localparam int NUM_INST    = 300;
	localparam int HOLD_CYCLES = 12;
	localparam int CYCLE_LIMIT = 4 * NUM_INST + 200;

	// expected issue, imm only feeds the operand model
	typedef struct {
		id_pkg::inst_t     inst;
		id_pkg::alusel_t   alusel;
		id_pkg::aluop_t    aluop;
		logic              wreg;
		id_pkg::reg_addr_t waddr;
		logic              r1_read;
		id_pkg::reg_addr_t r1_addr;
		logic              r2_read;
		id_pkg::reg_addr_t r2_addr;
		id_pkg::word_t     imm;
	} issue_t;

	logic              clk;
	logic              reset_n;
	id_pkg::inst_t     inst_i;
	logic              inst_valid_i;
	logic              inst_ready_o;
	id_pkg::word_t     reg1_data_i;
	id_pkg::word_t     reg2_data_i;
	logic              reg1_read_o;
	id_pkg::reg_addr_t reg1_addr_o;
	logic              reg2_read_o;
	id_pkg::reg_addr_t reg2_addr_o;
	logic              ex_we_i;
	id_pkg::reg_addr_t ex_waddr_i;
	id_pkg::word_t     ex_wdata_i;
	logic              mem_we_i;
	id_pkg::reg_addr_t mem_waddr_i;
	id_pkg::word_t     mem_wdata_i;
	logic              credit_return_i;
	logic              issue_valid_o;
	id_pkg::alusel_t   alusel_o;
	id_pkg::aluop_t    aluop_o;
	logic              wreg_o;
	id_pkg::reg_addr_t waddr_o;
	id_pkg::word_t     reg1_data_o;
	id_pkg::word_t     reg2_data_o;

	integer        seed = 32'he9b99e19;
	id_pkg::word_t rf [32];
	issue_t        exp_q [$];
	int            model_cnt;
	int            accepted_cnt;
	int            issued_cnt;
	int            cycles;
	logic          acc_last;
	int            err_word;
	int            err_ctrl;
	int            err_credit;
	int            err_other;
	logic [5:0]    imm_ops [8];
	logic [5:0]    r_fns [16];
	// j, special2, lw, sw and movz, mfhi, mult, sync
	logic [5:0]    bad_ops [4] = '{6'b000010, 6'b011100, 6'b100011, 6'b101011};
	logic [5:0]    bad_fns [4] = '{6'b001010, 6'b010000, 6'b011000, 6'b001111};

	id_top DUT (.*);

	// register file answers combinationally
	assign reg1_data_i = rf[reg1_addr_o];
	assign reg2_data_i = rf[reg2_addr_o];

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// random helpers and reference model
	//////////////////////////////////////////////////
	function automatic int rand_below(int n);
		rand_below = int'($unsigned($random(seed)) % n);
	endfunction

	task automatic make_inst(output id_pkg::inst_t inst);
		int         kind;
		logic [5:0] op;
		logic [5:0] fn;
		kind = rand_below(16);
		op   = id_pkg::op_special;
		fn   = r_fns[rand_below(16)];
		if (kind < 7)
			op = imm_ops[rand_below(8)];
		else if (kind == 14)
			op = bad_ops[rand_below(4)];
		else if (kind == 15)
			fn = bad_fns[rand_below(4)];
		// small register range so forwarding hits are common
		inst = {op, 5'(rand_below(8)), 5'(rand_below(8)), 16'($random(seed))};
		if (op == id_pkg::op_special)
			inst[15:0] = {5'(rand_below(8)), 5'(rand_below(32)), fn};
	endtask

	function automatic issue_t predict(id_pkg::inst_t inst);
		issue_t     p;
		logic [5:0] op;
		logic [5:0] fn;
		logic       const_shift;
		op          = inst[31:26];
		fn          = inst[5:0];
		const_shift = (fn == id_pkg::fn_sll) || (fn == id_pkg::fn_srl) || (fn == id_pkg::fn_sra);
		p = '{inst, id_pkg::sel_nop, 8'h00, 1'b0, 5'd0, 1'b0, inst[25:21], 1'b0, inst[20:16], 32'd0};
		if (op inside {id_pkg::op_ori, id_pkg::op_andi, id_pkg::op_xori, id_pkg::op_lui}) begin
			p.alusel = id_pkg::sel_logic;
			p.imm    = {16'h0000, inst[15:0]};
		end else if (op inside {id_pkg::op_addi, id_pkg::op_addiu, id_pkg::op_slti,
				id_pkg::op_sltiu}) begin
			p.alusel = id_pkg::sel_arith;
			p.imm    = {{16{inst[15]}}, inst[15:0]};
		end else if (op == id_pkg::op_special) begin
			if (fn inside {id_pkg::fn_and, id_pkg::fn_or, id_pkg::fn_xor, id_pkg::fn_nor})
				p.alusel = id_pkg::sel_logic;
			else if (const_shift || fn inside {id_pkg::fn_sllv, id_pkg::fn_srlv, id_pkg::fn_srav})
				p.alusel = id_pkg::sel_shift;
			else if (fn inside {id_pkg::fn_add, id_pkg::fn_addu, id_pkg::fn_sub, id_pkg::fn_subu,
					id_pkg::fn_slt, id_pkg::fn_sltu})
				p.alusel = id_pkg::sel_arith;
		end
		if (p.alusel != id_pkg::sel_nop) begin
			p.wreg = 1'b1;
			if (op == id_pkg::op_special) begin
				p.aluop   = {2'b00, fn};
				p.waddr   = inst[15:11];
				p.r1_read = !const_shift;
				p.r2_read = 1'b1;
				if (const_shift)
					p.imm = {27'd0, inst[10:6]};
			end else begin
				p.aluop   = {2'b00, op};
				p.waddr   = inst[20:16];
				p.r1_read = 1'b1;
			end
		end
		return p;
	endfunction

	function automatic string inst_name(issue_t p);
		if (p.alusel == id_pkg::sel_nop)
			return "bubble";
		return $sformatf("%s_%02h", (p.inst[31:26] == id_pkg::op_special) ? "fn" : "op", p.aluop);
	endfunction

	// execute beats memory beats register file
	function automatic id_pkg::word_t operand_model(logic rd, id_pkg::reg_addr_t a,
			id_pkg::word_t imm);
		if (!rd)
			return imm;
		if (ex_we_i && ex_waddr_i == a)
			return ex_wdata_i;
		if (mem_we_i && mem_waddr_i == a)
			return mem_wdata_i;
		return rf[a];
	endfunction

	//////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////
	task automatic report_mismatch(string name, logic [31:0] e, logic [31:0] a);
		$display("** Error %s expected %0h actual %0h", name, e, a);
		err_ctrl++;
	endtask

	task automatic check_word(string name, id_pkg::word_t e, id_pkg::word_t a);
		if (a !== e) begin
			$display("** Error %s expected %08h actual %08h", name, e, a);
			err_word++;
		end
	endtask

	task automatic check_ctrl(string name, issue_t e);
		if (alusel_o !== e.alusel)
			report_mismatch({name, ".alusel"}, 32'(e.alusel), 32'(alusel_o));
		if (aluop_o !== e.aluop)
			report_mismatch({name, ".aluop"}, 32'(e.aluop), 32'(aluop_o));
		if (wreg_o !== e.wreg)
			report_mismatch({name, ".wreg"}, 32'(e.wreg), 32'(wreg_o));
		if (waddr_o !== e.waddr)
			report_mismatch({name, ".waddr"}, 32'(e.waddr), 32'(waddr_o));
		if (reg1_read_o !== e.r1_read || reg1_addr_o !== e.r1_addr)
			report_mismatch({name, ".reg1"}, {26'd0, e.r1_read, e.r1_addr},
				{26'd0, reg1_read_o, reg1_addr_o});
		if (reg2_read_o !== e.r2_read || reg2_addr_o !== e.r2_addr)
			report_mismatch({name, ".reg2"}, {26'd0, e.r2_read, e.r2_addr},
				{26'd0, reg2_read_o, reg2_addr_o});
	endtask

	task automatic check_credit(string name, logic e, logic a);
		if (a !== e) begin
			$display("** Error %s expected %0b actual %0b", name, e, a);
			err_credit++;
		end
	endtask

	//////////////////////////////////////////////////
	// per-cycle drive and check
	//////////////////////////////////////////////////
	task automatic drive_inputs(int cyc);
		id_pkg::inst_t inst;
		logic          hold;
		hold = (cyc < HOLD_CYCLES);
		// a refused instruction stays on the bus
		if (!(inst_valid_i && !acc_last)) begin
			if (accepted_cnt < NUM_INST && (hold || rand_below(5) != 0)) begin
				make_inst(inst);
				inst_i       = inst;
				inst_valid_i = 1'b1;
			end else begin
				inst_valid_i = 1'b0;
			end
		end
		credit_return_i = 1'b0;
		if (!hold && model_cnt < `ID_CREDITS && rand_below(4) != 0)
			credit_return_i = 1'b1;
		ex_we_i     = (rand_below(2) == 1);
		ex_waddr_i  = 5'(rand_below(8));
		ex_wdata_i  = 32'($random(seed));
		mem_we_i    = (rand_below(2) == 1);
		mem_waddr_i = 5'(rand_below(8));
		mem_wdata_i = 32'($random(seed));
	endtask

	task automatic check_cycle();
		issue_t e;
		logic   acc;
		if (issue_valid_o) begin
			if (exp_q.size() == 0) begin
				$display("issue_valid_o rose with no accepted instruction pending");
				err_other++;
			end else begin
				e = exp_q.pop_front();
				check_ctrl(inst_name(e), e);
				check_word({inst_name(e), ".op1"}, operand_model(e.r1_read, e.r1_addr, e.imm),
					reg1_data_o);
				check_word({inst_name(e), ".op2"}, operand_model(e.r2_read, e.r2_addr, e.imm),
					reg2_data_o);
				issued_cnt++;
			end
		end else if (exp_q.size() != 0) begin
			$display("accepted instruction %08h was never issued", exp_q[0].inst);
			exp_q.delete(0);
			err_other++;
		end
		check_credit("ready", (model_cnt != 0), inst_ready_o);
		acc = inst_valid_i && (model_cnt != 0);
		if (acc) begin
			exp_q.push_back(predict(inst_i));
			accepted_cnt++;
		end
		if (acc && !credit_return_i)
			model_cnt--;
		else if (!acc && credit_return_i)
			model_cnt++;
		acc_last = acc;
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////
	initial begin
		int     cyc;
		issue_t rst_exp;
		imm_ops = '{id_pkg::op_ori, id_pkg::op_andi, id_pkg::op_xori, id_pkg::op_lui,
			id_pkg::op_addi, id_pkg::op_addiu, id_pkg::op_slti, id_pkg::op_sltiu};
		r_fns   = '{id_pkg::fn_and, id_pkg::fn_or, id_pkg::fn_xor, id_pkg::fn_nor,
			id_pkg::fn_sll, id_pkg::fn_srl, id_pkg::fn_sra, id_pkg::fn_sllv, id_pkg::fn_srlv,
			id_pkg::fn_srav, id_pkg::fn_add, id_pkg::fn_addu, id_pkg::fn_sub, id_pkg::fn_subu,
			id_pkg::fn_slt, id_pkg::fn_sltu};
		for (int i = 0; i < 32; i++)
			rf[i] = 32'(i + 1) * 32'h9e37_79b9;
		reset_n = 1'b0;
		inst_i = '0;
		inst_valid_i = 1'b0;
		credit_return_i = 1'b0;
		ex_we_i = 1'b0;
		ex_waddr_i = '0;
		ex_wdata_i = '0;
		mem_we_i = 1'b0;
		mem_waddr_i = '0;
		mem_wdata_i = '0;
		model_cnt = `ID_CREDITS;
		{accepted_cnt, issued_cnt, err_word, err_ctrl, err_credit, err_other} = '0;
		acc_last = 1'b0;
		repeat (2) @(posedge clk);
		#1 reset_n = 1'b1;

		// idle state out of reset
		@(negedge clk);
		rst_exp = predict(32'hfc00_0000);
		check_ctrl("reset", rst_exp);
		check_word("reset.op1", 32'd0, reg1_data_o);
		check_word("reset.op2", 32'd0, reg2_data_o);
		check_credit("reset.ready", 1'b1, inst_ready_o);
		if (issue_valid_o) begin
			$display("issue_valid_o is high right after reset");
			err_other++;
		end

		cyc = 0;
		while (issued_cnt < NUM_INST || model_cnt != `ID_CREDITS) begin
			@(posedge clk);
			#1 drive_inputs(cyc);
			@(negedge clk);
			check_cycle();
			if (cyc == HOLD_CYCLES - 1)
				check_credit("credits.exhausted", 1'b0, inst_ready_o);
			cyc++;
		end

		check_credit("credits.restored", 1'b1, inst_ready_o);
		if (accepted_cnt != issued_cnt || exp_q.size() != 0) begin
			$display("%0d instructions accepted but %0d issued", accepted_cnt, issued_cnt);
			err_other++;
		end
		$display("errors: word %0d ctrl %0d credit %0d other %0d",
			err_word, err_ctrl, err_credit, err_other);
		if (err_word + err_ctrl + err_credit + err_other == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// watchdog
	initial begin
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles >= CYCLE_LIMIT) begin
				$display("timeout after %0d cycles with %0d of %0d instructions issued",
					cycles, issued_cnt, NUM_INST);
				$display("Simulation failed");
				$finish;
			end
		end
	end

endmodule
